// File: collector_pkg.sv
// Stream collector definitions
`default_nettype none

package collector_pkg;

  // ------------------------------
  // Widths and depths
  // ------------------------------
  localparam int beat_w     = 512;
  localparam int fold_w     = beat_w / 8;  // One bit per input byte
  localparam int lane_depth = 16;
  localparam int out_depth  = 8;
  localparam int lane_count = 2;

  // ------------------------------
  // Queue payloads
  // ------------------------------

  // Lane queue entry of 513 bits
  typedef struct packed {
    logic              last;
    logic [beat_w-1:0] data;
  } lane_beat_t;

  // Output queue entry of 66 bits
  typedef struct packed {
    logic              lane;
    logic              last;
    logic [fold_w-1:0] word;
  } out_word_t;

endpackage

`default_nettype wire

// File: sync_fifo.sv
// Register array FIFO
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t wdata,
  input  logic     pop,
  output payload_t rdata,
  output logic     empty,
  output logic     full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t   mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;  // Occupancy keeps all entries usable
  logic             do_push;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_push = push && !full;   // Ignored when full
  assign do_pop  = pop && !empty;   // Ignored when empty

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push and pop together
      endcase
    end
  end

  // First word falls through from the head
  assign rdata = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));

endmodule

`default_nettype wire

// File: collector_lane.sv
// Collector receive lane
`timescale 1ns/1ns
`default_nettype none

module collector_lane import collector_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // Stream input
  input  logic              rx_valid,
  input  logic [beat_w-1:0] rx_data,
  input  logic              rx_last,
  output logic              rx_ready,
  // Folded head beat towards the merger
  output logic [fold_w-1:0] lane_word,
  output logic              lane_last,
  output logic              lane_rdy,
  input  logic              lane_ren
);

  lane_beat_t in_beat;
  lane_beat_t head_beat;
  logic       fifo_push;
  logic       fifo_empty;
  logic       fifo_full;

  assign in_beat.data = rx_data;
  assign in_beat.last = rx_last;
  assign fifo_push    = rx_valid && rx_ready;

  sync_fifo #(
    .payload_t (lane_beat_t),
    .depth     (lane_depth)
  ) u_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (fifo_push),
    .wdata (in_beat),
    .pop   (lane_ren),
    .rdata (head_beat),
    .empty (fifo_empty),
    .full  (fifo_full)
  );

  assign rx_ready = !fifo_full;   // Accept while there is room
  assign lane_rdy = !fifo_empty;  // Head beat is valid

  // ------------------------------
  // Byte parity fold of the head
  // ------------------------------
  // Byte k of the beat gives bit k of the word
  always_comb begin
    for (int k = 0; k < fold_w; k++) begin
      lane_word[k] = ^head_beat.data[8*k +: 8];
    end
  end

  assign lane_last = head_beat.last;

endmodule

`default_nettype wire

// File: lane_merger.sv
// Frame merger for two lanes
`timescale 1ns/1ns
`default_nettype none

module lane_merger import collector_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // Lane 0
  input  logic [fold_w-1:0] lane0_word,
  input  logic              lane0_last,
  input  logic              lane0_rdy,
  output logic              lane0_ren,
  // Lane 1
  input  logic [fold_w-1:0] lane1_word,
  input  logic              lane1_last,
  input  logic              lane1_rdy,
  output logic              lane1_ren,
  // Output queue read port
  output logic [fold_w-1:0] out_word,
  output logic              out_lane,
  output logic              out_last,
  output logic              out_rdy,
  input  logic              out_ren
);

  logic [fold_w-1:0]     word_in [lane_count];
  logic [lane_count-1:0] last_in;
  logic [lane_count-1:0] rdy;
  logic [lane_count-1:0] ren;

  logic      frame_open;  // A frame has started but not ended
  logic      cur_lane;    // Lane that owns the open frame
  logic      last_lane;   // Lane served most recently
  logic      sel;
  logic      take;
  out_word_t push_word;
  out_word_t head_word;
  logic      out_empty;
  logic      out_full;

  assign word_in[0] = lane0_word;
  assign word_in[1] = lane1_word;
  assign last_in    = {lane1_last, lane0_last};
  assign rdy        = {lane1_rdy, lane0_rdy};
  assign lane0_ren  = ren[0];
  assign lane1_ren  = ren[1];

  // ------------------------------
  // Lane choice
  // ------------------------------
  always_comb begin
    sel  = last_lane;
    take = 1'b0;
    ren  = '0;
    if (!out_full) begin
      if (frame_open) begin
        sel  = cur_lane;  // Stay on the lane until the frame closes
        take = rdy[cur_lane];
      end else if (rdy[0] && rdy[1]) begin
        sel  = !last_lane;
        take = 1'b1;
      end else if (rdy[0] || rdy[1]) begin
        sel  = rdy[1];
        take = 1'b1;
      end
    end
    if (take) ren[sel] = 1'b1;
  end

  assign push_word.lane = sel;
  assign push_word.last = last_in[sel];
  assign push_word.word = word_in[sel];

  // ------------------------------
  // Frame state
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_open <= 1'b0;
      cur_lane   <= 1'b0;
      last_lane  <= 1'b1;  // Lane 0 wins the first tie
    end else if (take) begin
      last_lane  <= sel;
      frame_open <= !last_in[sel];
      if (!frame_open) cur_lane <= sel;
    end
  end

  sync_fifo #(
    .payload_t (out_word_t),
    .depth     (out_depth)
  ) u_out_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (take),
    .wdata (push_word),
    .pop   (out_ren),
    .rdata (head_word),
    .empty (out_empty),
    .full  (out_full)
  );

  assign out_rdy  = !out_empty;
  assign out_word = head_word.word;
  assign out_lane = head_word.lane;
  assign out_last = head_word.last;

endmodule

`default_nettype wire

// File: collector_top.sv
// Two lane stream collector
`timescale 1ns/1ns
`default_nettype none

module collector_top import collector_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // Lane 0 stream
  input  logic              rx0_valid,
  input  logic [beat_w-1:0] rx0_data,
  input  logic              rx0_last,
  output logic              rx0_ready,
  // Lane 1 stream
  input  logic              rx1_valid,
  input  logic [beat_w-1:0] rx1_data,
  input  logic              rx1_last,
  output logic              rx1_ready,
  // Output queue
  output logic [fold_w-1:0] out_word,
  output logic              out_lane,
  output logic              out_last,
  output logic              out_rdy,
  input  logic              out_ren
);

  logic [fold_w-1:0]     lane_word [lane_count];
  logic [lane_count-1:0] lane_last;
  logic [lane_count-1:0] lane_rdy;
  logic [lane_count-1:0] lane_ren;

  // ------------------------------
  // Receive lanes
  // ------------------------------
  collector_lane u_lane0 (
    .clk       (clk),
    .rst       (rst),
    .rx_valid  (rx0_valid),
    .rx_data   (rx0_data),
    .rx_last   (rx0_last),
    .rx_ready  (rx0_ready),
    .lane_word (lane_word[0]),
    .lane_last (lane_last[0]),
    .lane_rdy  (lane_rdy[0]),
    .lane_ren  (lane_ren[0])
  );

  collector_lane u_lane1 (
    .clk       (clk),
    .rst       (rst),
    .rx_valid  (rx1_valid),
    .rx_data   (rx1_data),
    .rx_last   (rx1_last),
    .rx_ready  (rx1_ready),
    .lane_word (lane_word[1]),
    .lane_last (lane_last[1]),
    .lane_rdy  (lane_rdy[1]),
    .lane_ren  (lane_ren[1])
  );

  // Merge into the output queue
  lane_merger u_merger (
    .clk        (clk),
    .rst        (rst),
    .lane0_word (lane_word[0]),
    .lane0_last (lane_last[0]),
    .lane0_rdy  (lane_rdy[0]),
    .lane0_ren  (lane_ren[0]),
    .lane1_word (lane_word[1]),
    .lane1_last (lane_last[1]),
    .lane1_rdy  (lane_rdy[1]),
    .lane1_ren  (lane_ren[1]),
    .out_word   (out_word),
    .out_lane   (out_lane),
    .out_last   (out_last),
    .out_rdy    (out_rdy),
    .out_ren    (out_ren)
  );

endmodule

`default_nettype wire

// File: tb_collector.sv
// Stream collector testbench
`timescale 1ns/1ns
`default_nettype none

module tb_collector import collector_pkg::*; ();

  localparam int beats_per_lane = 100;
  localparam int stall_cycles   = 60;
  localparam int drain_cycles   = 20;
  localparam int limit_cycles   = 2 * beats_per_lane * 40 + 1000;

  logic              clk;
  logic              rst;
  logic              rx0_valid;
  logic [beat_w-1:0] rx0_data;
  logic              rx0_last;
  logic              rx0_ready;
  logic              rx1_valid;
  logic [beat_w-1:0] rx1_data;
  logic              rx1_last;
  logic              rx1_ready;
  logic [fold_w-1:0] out_word;
  logic              out_lane;
  logic              out_last;
  logic              out_rdy;
  logic              out_ren;

  logic [31:0]       rng_state = 32'd65237;
  logic [fold_w:0]   exp_q0 [$];  // {last, fold} per accepted beat
  logic [fold_w:0]   exp_q1 [$];
  int                errors    = 0;
  int                accepted  = 0;
  int                out_count = 0;
  logic              prev_last = 1'b1;
  logic              prev_lane = 1'b0;
  logic              full0_seen = 1'b0;
  logic              full1_seen = 1'b0;

  collector_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .rx0_valid (rx0_valid),
    .rx0_data  (rx0_data),
    .rx0_last  (rx0_last),
    .rx0_ready (rx0_ready),
    .rx1_valid (rx1_valid),
    .rx1_data  (rx1_data),
    .rx1_last  (rx1_last),
    .rx1_ready (rx1_ready),
    .out_word  (out_word),
    .out_lane  (out_lane),
    .out_last  (out_last),
    .out_rdy   (out_rdy),
    .out_ren   (out_ren)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [beat_w-1:0] random_beat();
    logic [beat_w-1:0] d;
    for (int i = 0; i < beat_w / 32; i++) begin
      d[32*i +: 32] = next_rand();
    end
    return d;
  endfunction

  // Parity of byte k lands in bit k
  function automatic logic [fold_w-1:0] ref_fold(input logic [beat_w-1:0] d);
    logic [fold_w-1:0] f;
    f = '0;
    for (int i = 0; i < beat_w; i++) begin
      f[i / 8] = f[i / 8] ^ d[i];
    end
    return f;
  endfunction

  task automatic drive_rx(input int lane, input logic valid, input logic [beat_w-1:0] data,
                          input logic last);
    if (lane == 0) begin
      rx0_valid = valid;
      rx0_data  = data;
      rx0_last  = last;
    end else begin
      rx1_valid = valid;
      rx1_data  = data;
      rx1_last  = last;
    end
  endtask

  // Random frames of 1 to 6 beats with random valid gaps
  task automatic send_lane(input int lane);
    int                sent;
    int                frame_left;
    logic [beat_w-1:0] data;
    logic              last;
    sent       = 0;
    frame_left = 0;
    while (sent < beats_per_lane) begin
      if (frame_left == 0) frame_left = 1 + int'(next_rand() % 6);
      if (frame_left > beats_per_lane - sent) frame_left = beats_per_lane - sent;
      data = random_beat();
      last = (frame_left == 1);
      while ((next_rand() % 4) == 0) begin
        @(negedge clk);
      end
      drive_rx(lane, 1'b1, data, last);
      while ((lane == 0) ? !rx0_ready : !rx1_ready) @(negedge clk);
      @(posedge clk);
      // Accepted at this edge
      if (lane == 0) exp_q0.push_back({last, ref_fold(data)});
      else exp_q1.push_back({last, ref_fold(data)});
      accepted++;
      sent++;
      frame_left--;
      @(negedge clk);
      drive_rx(lane, 1'b0, '0, 1'b0);
    end
  endtask

  // ------------------------------
  // Output read strobe
  // ------------------------------
  initial begin
    wait (!rst);
    @(negedge clk);
    repeat (40) begin
      out_ren = (next_rand() % 2) != 0;
      @(negedge clk);
    end
    out_ren = 1'b0;  // Stall so both lanes back up
    repeat (stall_cycles) @(negedge clk);
    forever begin
      out_ren = (next_rand() % 4) != 0;
      @(negedge clk);
    end
  end

  always @(negedge clk) begin
    if (!rst && !rx0_ready) full0_seen = 1'b1;
    if (!rst && !rx1_ready) full1_seen = 1'b1;
  end

  // ------------------------------
  // Scoreboard
  // ------------------------------
  always @(posedge clk) begin
    logic [fold_w:0] exp;
    if (!rst && out_rdy && out_ren) begin
      out_count++;
      assert ((out_lane ? exp_q1.size() : exp_q0.size()) > 0) else begin
        errors++;
        $display("output word on lane %0d with no beat outstanding", out_lane);
      end
      if ((out_lane ? exp_q1.size() : exp_q0.size()) > 0) begin
        exp = out_lane ? exp_q1.pop_front() : exp_q0.pop_front();
        assert (out_word == exp[fold_w-1:0]) else begin
          errors++;
          $display("error: out_word lane %0d got %h expected %h", out_lane, out_word,
                   exp[fold_w-1:0]);
        end
        assert (out_last == exp[fold_w]) else begin
          errors++;
          $display("error: out_last lane %0d got %h expected %h", out_lane, out_last,
                   exp[fold_w]);
        end
      end
      if (!prev_last) begin
        assert (out_lane == prev_lane) else begin
          errors++;
          $display("error: out_lane inside frame got %h expected %h", out_lane, prev_lane);
        end
      end
      prev_last = out_last;
      prev_lane = out_lane;
    end
  end

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: output did not drain within %0d cycles", limit_cycles);
    $display("errors: %0d, words checked: %0d of %0d", errors, out_count, accepted);
    $display("Errors found");
    $finish;
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    rst       = 1'b1;
    rx0_valid = 1'b0;
    rx0_data  = '0;
    rx0_last  = 1'b0;
    rx1_valid = 1'b0;
    rx1_data  = '0;
    rx1_last  = 1'b0;
    out_ren   = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (!out_rdy) else begin
      errors++;
      $display("error: out_rdy after reset got %h expected 0", out_rdy);
    end
    assert (rx0_ready && rx1_ready) else begin
      errors++;
      $display("error: rx0_ready/rx1_ready after reset got %h/%h expected 1/1",
               rx0_ready, rx1_ready);
    end
    fork
      send_lane(0);
      send_lane(1);
    join
    wait (out_count >= accepted);
    // Extra words would surface here
    repeat (drain_cycles) @(negedge clk);
    assert (out_count == accepted) else begin
      errors++;
      $display("error: out_count got %h expected %h", out_count, accepted);
    end
    assert (!out_rdy) else begin
      errors++;
      $display("error: out_rdy after drain got %h expected 0", out_rdy);
    end
    assert (exp_q0.size() == 0 && exp_q1.size() == 0) else begin
      errors++;
      $display("accepted beats were never delivered");
    end
    assert (full0_seen && full1_seen) else begin
      errors++;
      $display("a lane ready never dropped during the output stall");
    end
    $display("errors: %0d, words checked: %0d of %0d", errors, out_count, accepted);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
collector_pkg.sv
sync_fifo.sv
collector_lane.sv
lane_merger.sv
collector_top.sv
tb_collector.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_collector
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = No errors

SOURCES = $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
